// ==== logic/dpm_map_pkg.sv ====
/*
 * Datapath memory address map: RAM and I/O windows and per-thread offsets
 */
package dpm_map_pkg;

    // Raw and local address widths
    localparam int unsigned ADDR_WIDTH     = 10;
    localparam int unsigned MEM_ADDR_WIDTH = 8;

    // RAM window, power-of-two aligned so the low bits index the RAM
    localparam int unsigned MEM_BASE_ADDR  = 256;
    localparam int unsigned MEM_BOUND_ADDR = 511;

    // I/O window sits right above the RAM window
    localparam int unsigned IO_BASE_ADDR       = 512;
    localparam int unsigned IO_PORT_COUNT      = 4;
    localparam int unsigned IO_PORT_ADDR_WIDTH = 2;
    localparam int unsigned IO_BOUND_ADDR      = IO_BASE_ADDR + IO_PORT_COUNT - 1;

    // ------------------------------------------------------------------
    // Threads

    localparam int unsigned THREAD_COUNT    = 2;
    localparam int unsigned THREAD_ID_WIDTH = $clog2(THREAD_COUNT);

    // Offset added inside the RAM window, wraps within the window
    localparam logic [MEM_ADDR_WIDTH-1:0] THREAD_OFFSET [0:THREAD_COUNT-1] = '{8'd0, 8'd64};

    // ------------------------------------------------------------------
    // Window checks shared by the translator and the range decoders

    function automatic logic in_ram_window(input logic [ADDR_WIDTH-1:0] addr);
        return (addr >= MEM_BASE_ADDR) && (addr <= MEM_BOUND_ADDR);
    endfunction

    function automatic logic in_io_window(input logic [ADDR_WIDTH-1:0] addr);
        return (addr >= IO_BASE_ADDR) && (addr <= IO_BOUND_ADDR);
    endfunction

endpackage

// ==== logic/dpm_data_pkg.sv ====
/*
 * Datapath memory data types: word, opcodes and the structs passed
 * between the translator, memory pair and ALU stages
 */
package dpm_data_pkg;

    localparam int unsigned WORD_WIDTH = 16;

    typedef logic [WORD_WIDTH-1:0] word_t;

    typedef enum logic [2:0] {
        op_add    = 3'd0,
        op_sub    = 3'd1,
        op_and    = 3'd2,
        op_or     = 3'd3,
        op_xor    = 3'd4,
        op_pass_a = 3'd5
    } alu_op_t;

    // Instruction as issued from outside, addresses still raw
    typedef struct packed {
        alu_op_t                                     op;
        logic [dpm_map_pkg::THREAD_ID_WIDTH-1:0]     thread;
        logic [dpm_map_pkg::ADDR_WIDTH-1:0]          src_a;
        logic [dpm_map_pkg::ADDR_WIDTH-1:0]          src_b;
        logic [dpm_map_pkg::ADDR_WIDTH-1:0]          dest;
    } instr_t;

    // After thread offset and I/O flagging
    typedef struct packed {
        alu_op_t                                     op;
        logic [dpm_map_pkg::ADDR_WIDTH-1:0]          addr_a;
        logic [dpm_map_pkg::ADDR_WIDTH-1:0]          addr_b;
        logic [dpm_map_pkg::ADDR_WIDTH-1:0]          dest;
        logic                                        a_is_io;
        logic                                        b_is_io;
        logic                                        dest_is_io;
    } xlat_req_t;

    // Write-back from the ALU into both banks
    typedef struct packed {
        logic                                        wren;
        logic [dpm_map_pkg::ADDR_WIDTH-1:0]          addr;
        logic                                        addr_is_io;
        word_t                                       data;
    } wb_req_t;

    // One word per I/O port
    typedef logic [dpm_map_pkg::IO_PORT_COUNT-1:0][WORD_WIDTH-1:0] io_bus_t;

endpackage

// ==== logic/mem_range_decoder.sv ====
/*
 * Range decoder: read and write enables from the RAM window base and bound
 */
module mem_range_decoder (
    input  logic [dpm_map_pkg::ADDR_WIDTH-1:0] read_addr,
    input  logic [dpm_map_pkg::ADDR_WIDTH-1:0] write_addr,
    input  logic                               write_request,

    output logic                               read_enable,
    output logic                               write_enable
);

    logic write_in_window;

    // Anything outside the window is disabled, address 0 included,
    // which gives the zero location: reads return zero, writes are dropped
    always_comb begin
        read_enable     = dpm_map_pkg::in_ram_window(read_addr);
        write_in_window = dpm_map_pkg::in_ram_window(write_addr);
        write_enable    = write_request && write_in_window;
    end

endmodule

// ==== logic/data_memory.sv ====
/*
 * Data memory bank: 256-word RAM with registered read, I/O read mux,
 * one-hot I/O write strobes and zero for unmapped reads
 */
module data_memory (
    input  logic                                   clock,
    input  logic                                   rst_n,

    // Read side
    input  logic                                   read_enable,
    input  logic [dpm_map_pkg::MEM_ADDR_WIDTH-1:0] read_addr,
    input  logic                                   read_addr_is_io,
    output dpm_data_pkg::word_t                    read_data,
    input  dpm_data_pkg::io_bus_t                  io_read_data,

    // Write side
    input  logic                                   write_enable,
    input  logic                                   write_request,
    input  logic [dpm_map_pkg::MEM_ADDR_WIDTH-1:0] write_addr,
    input  logic                                   write_addr_is_io,
    input  dpm_data_pkg::word_t                    write_data,
    output logic [dpm_map_pkg::IO_PORT_COUNT-1:0]  io_wren,
    output dpm_data_pkg::io_bus_t                  io_write_data
);

    localparam int unsigned MEM_DEPTH = 2 ** dpm_map_pkg::MEM_ADDR_WIDTH;
    localparam int unsigned PW        = dpm_map_pkg::IO_PORT_ADDR_WIDTH;

    dpm_data_pkg::word_t ram [0:MEM_DEPTH-1];

    logic [PW-1:0] read_port;
    logic [PW-1:0] write_port;

    always_comb begin
        read_port  = read_addr[PW-1:0];
        write_port = write_addr[PW-1:0];
    end

    // ----------------------------------------------------------------------
    // RAM write, no reset on contents

    always_ff @(posedge clock) begin
        if (write_enable) begin
            ram[write_addr] <= write_data;
        end
    end

    // ----------------------------------------------------------------------
    // Registered read: RAM, then I/O port, else zero

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            read_data <= '0;
        end else if (read_enable) begin
            // Old data on a same-cycle write to this address
            read_data <= ram[read_addr];
        end else if (read_addr_is_io) begin
            read_data <= io_read_data[read_port];
        end else begin
            read_data <= '0;
        end
    end

    // ----------------------------------------------------------------------
    // I/O write, combinational from the write-back request

    always_comb begin
        io_wren = '0;
        if (write_request && write_addr_is_io) begin
            io_wren[write_port] = 1'b1;
        end
    end

    // Every port sees the same word, io_wren picks the one that takes it
    assign io_write_data = {dpm_map_pkg::IO_PORT_COUNT{write_data}};

endmodule

// ==== logic/addr_translator.sv ====
/*
 * Address translator: registers one instruction per cycle, adds the thread
 * offset to RAM-window addresses and flags I/O-window addresses
 */
module addr_translator (
    input  logic                    clock,
    input  logic                    rst_n,

    input  logic                    instr_valid,
    input  dpm_data_pkg::instr_t    instr,

    output logic                    xlat_valid,
    output dpm_data_pkg::xlat_req_t xlat_req
);

    localparam int unsigned AW  = dpm_map_pkg::ADDR_WIDTH;
    localparam int unsigned MAW = dpm_map_pkg::MEM_ADDR_WIDTH;
    localparam int unsigned TW  = dpm_map_pkg::THREAD_ID_WIDTH;

    // Only the local index moves, so the sum stays in the RAM window
    function automatic logic [AW-1:0] offset_addr(
        input logic [AW-1:0] addr,
        input logic [TW-1:0] thread
    );
        logic [MAW-1:0] local_idx;
        local_idx = addr[MAW-1:0] + dpm_map_pkg::THREAD_OFFSET[thread];
        if (dpm_map_pkg::in_ram_window(addr)) begin
            return {addr[AW-1:MAW], local_idx};
        end
        return addr;
    endfunction

    dpm_data_pkg::xlat_req_t xlat_next;

    // ----------------------------------------------------------------------

    always_comb begin
        xlat_next.op         = instr.op;
        xlat_next.addr_a     = offset_addr(instr.src_a, instr.thread);
        xlat_next.addr_b     = offset_addr(instr.src_b, instr.thread);
        xlat_next.dest       = offset_addr(instr.dest, instr.thread);
        // I/O addresses pass through, port index is in the low bits
        xlat_next.a_is_io    = dpm_map_pkg::in_io_window(instr.src_a);
        xlat_next.b_is_io    = dpm_map_pkg::in_io_window(instr.src_b);
        xlat_next.dest_is_io = dpm_map_pkg::in_io_window(instr.dest);
    end

    // ----------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            xlat_valid <= 1'b0;
        end else begin
            xlat_valid <= instr_valid;
        end
        xlat_req <= xlat_next;
    end

endmodule

// ==== logic/datapath_memory.sv ====
/*
 * Memory pair: banks A and B with their own range decoders, plus the
 * control fields delayed alongside the read
 */
module datapath_memory (
    input  logic                               clock,
    input  logic                               rst_n,

    input  logic                               xlat_valid,
    input  dpm_data_pkg::xlat_req_t            xlat_req,
    input  dpm_data_pkg::wb_req_t              wb_req,

    input  dpm_data_pkg::io_bus_t              io_read_data_a,
    input  dpm_data_pkg::io_bus_t              io_read_data_b,

    output dpm_data_pkg::word_t                read_data_a,
    output dpm_data_pkg::word_t                read_data_b,
    output logic                               stage_valid,
    output dpm_data_pkg::alu_op_t              stage_op,
    output logic [dpm_map_pkg::ADDR_WIDTH-1:0] stage_dest,
    output logic                               stage_dest_is_io,

    output logic [dpm_map_pkg::IO_PORT_COUNT-1:0] io_wren_a,
    output logic [dpm_map_pkg::IO_PORT_COUNT-1:0] io_wren_b,
    output dpm_data_pkg::io_bus_t              io_write_data_a,
    output dpm_data_pkg::io_bus_t              io_write_data_b
);

    localparam int unsigned MAW = dpm_map_pkg::MEM_ADDR_WIDTH;

    logic           read_enable_a;
    logic           write_enable_a;
    logic           read_enable_b;
    logic           write_enable_b;

    // Window is power-of-two aligned, so the upper bits just drop
    logic [MAW-1:0] read_addr_a_local;
    logic [MAW-1:0] read_addr_b_local;
    logic [MAW-1:0] write_addr_local;

    assign read_addr_a_local = xlat_req.addr_a[MAW-1:0];
    assign read_addr_b_local = xlat_req.addr_b[MAW-1:0];
    assign write_addr_local  = wb_req.addr[MAW-1:0];

    // ----------------------------------------------------------------------
    // Bank A

    mem_range_decoder decoder_a (
        .read_addr        (xlat_req.addr_a),
        .write_addr       (wb_req.addr),
        .write_request    (wb_req.wren),
        .read_enable      (read_enable_a),
        .write_enable     (write_enable_a)
    );

    data_memory bank_a (
        .clock            (clock),
        .rst_n            (rst_n),
        .read_enable      (read_enable_a),
        .read_addr        (read_addr_a_local),
        .read_addr_is_io  (xlat_req.a_is_io),
        .read_data        (read_data_a),
        .io_read_data     (io_read_data_a),
        .write_enable     (write_enable_a),
        .write_request    (wb_req.wren),
        .write_addr       (write_addr_local),
        .write_addr_is_io (wb_req.addr_is_io),
        .write_data       (wb_req.data),
        .io_wren          (io_wren_a),
        .io_write_data    (io_write_data_a)
    );

    // ----------------------------------------------------------------------
    // Bank B, same write-back as bank A so the two stay mirrored

    mem_range_decoder decoder_b (
        .read_addr        (xlat_req.addr_b),
        .write_addr       (wb_req.addr),
        .write_request    (wb_req.wren),
        .read_enable      (read_enable_b),
        .write_enable     (write_enable_b)
    );

    data_memory bank_b (
        .clock            (clock),
        .rst_n            (rst_n),
        .read_enable      (read_enable_b),
        .read_addr        (read_addr_b_local),
        .read_addr_is_io  (xlat_req.b_is_io),
        .read_data        (read_data_b),
        .io_read_data     (io_read_data_b),
        .write_enable     (write_enable_b),
        .write_request    (wb_req.wren),
        .write_addr       (write_addr_local),
        .write_addr_is_io (wb_req.addr_is_io),
        .write_data       (wb_req.data),
        .io_wren          (io_wren_b),
        .io_write_data    (io_write_data_b)
    );

    // ----------------------------------------------------------------------
    // Control fields follow the read data by one stage

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= xlat_valid;
        end
        stage_op         <= xlat_req.op;
        stage_dest       <= xlat_req.dest;
        stage_dest_is_io <= xlat_req.dest_is_io;
    end

endmodule

// ==== logic/result_alu.sv ====
/*
 * Result ALU: combines the two read words and registers the write-back
 */
module result_alu (
    input  logic                               clock,
    input  logic                               rst_n,

    input  logic                               stage_valid,
    input  dpm_data_pkg::alu_op_t              stage_op,
    input  logic [dpm_map_pkg::ADDR_WIDTH-1:0] stage_dest,
    input  logic                               stage_dest_is_io,
    input  dpm_data_pkg::word_t                read_data_a,
    input  dpm_data_pkg::word_t                read_data_b,

    output dpm_data_pkg::wb_req_t              wb_req
);

    dpm_data_pkg::word_t result;

    // Add and sub wrap at the word width
    always_comb begin
        case (stage_op)
            dpm_data_pkg::op_add:    result = read_data_a + read_data_b;
            dpm_data_pkg::op_sub:    result = read_data_a - read_data_b;
            dpm_data_pkg::op_and:    result = read_data_a & read_data_b;
            dpm_data_pkg::op_or:     result = read_data_a | read_data_b;
            dpm_data_pkg::op_xor:    result = read_data_a ^ read_data_b;
            dpm_data_pkg::op_pass_a: result = read_data_a;
            default:                 result = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Write-back request, drives both banks' write ports

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wb_req.wren <= 1'b0;
        end else begin
            wb_req.wren <= stage_valid;
        end
        wb_req.addr       <= stage_dest;
        wb_req.addr_is_io <= stage_dest_is_io;
        wb_req.data       <= result;
    end

endmodule

// ==== logic/dpm_top.sv ====
/*
 * Datapath memory subsystem top: translator, memory pair and result ALU
 */
module dpm_top (
    input  logic                                  clock,
    input  logic                                  rst_n,

    input  logic                                  instr_valid,
    input  dpm_data_pkg::instr_t                  instr,

    input  dpm_data_pkg::io_bus_t                 io_read_data_a,
    input  dpm_data_pkg::io_bus_t                 io_read_data_b,
    output logic [dpm_map_pkg::IO_PORT_COUNT-1:0] io_wren_a,
    output logic [dpm_map_pkg::IO_PORT_COUNT-1:0] io_wren_b,
    output dpm_data_pkg::io_bus_t                 io_write_data_a,
    output dpm_data_pkg::io_bus_t                 io_write_data_b
);

    logic                               xlat_valid;
    dpm_data_pkg::xlat_req_t            xlat_req;
    dpm_data_pkg::word_t                read_data_a;
    dpm_data_pkg::word_t                read_data_b;
    logic                               stage_valid;
    dpm_data_pkg::alu_op_t              stage_op;
    logic [dpm_map_pkg::ADDR_WIDTH-1:0] stage_dest;
    logic                               stage_dest_is_io;
    dpm_data_pkg::wb_req_t              wb_req;

    addr_translator addr_translator_inst (
        .clock            (clock),
        .rst_n            (rst_n),
        .instr_valid      (instr_valid),
        .instr            (instr),
        .xlat_valid       (xlat_valid),
        .xlat_req         (xlat_req)
    );

    datapath_memory datapath_memory_inst (
        .clock            (clock),
        .rst_n            (rst_n),
        .xlat_valid       (xlat_valid),
        .xlat_req         (xlat_req),
        .wb_req           (wb_req),
        .io_read_data_a   (io_read_data_a),
        .io_read_data_b   (io_read_data_b),
        .read_data_a      (read_data_a),
        .read_data_b      (read_data_b),
        .stage_valid      (stage_valid),
        .stage_op         (stage_op),
        .stage_dest       (stage_dest),
        .stage_dest_is_io (stage_dest_is_io),
        .io_wren_a        (io_wren_a),
        .io_wren_b        (io_wren_b),
        .io_write_data_a  (io_write_data_a),
        .io_write_data_b  (io_write_data_b)
    );

    result_alu result_alu_inst (
        .clock            (clock),
        .rst_n            (rst_n),
        .stage_valid      (stage_valid),
        .stage_op         (stage_op),
        .stage_dest       (stage_dest),
        .stage_dest_is_io (stage_dest_is_io),
        .read_data_a      (read_data_a),
        .read_data_b      (read_data_b),
        .wb_req           (wb_req)
    );

endmodule

// ==== dv/clock_gen.sv ====
/*
 * Testbench clock source, free running with a 20 ns period
 */
module clock_gen (
    output logic clock
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 10;

    initial begin
        clock = 1'b0;
        forever begin
            #(HALF_PERIOD) clock = ~clock;
        end
    end

endmodule

// ==== dv/dpm_tb.sv ====
/*
 * Datapath memory testbench: table-driven instructions checked against
 * a RAM model, the address translation rule and the ALU rule
 */
module dpm_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_SINGLE = 18;
    localparam int NUM_BURST  = 3;
    localparam int NUM_TESTS  = NUM_SINGLE + NUM_BURST;
    localparam int LATENCY    = 3;
    localparam int WAIT_LIMIT = 10;
    localparam int IO0        = dpm_map_pkg::IO_BASE_ADDR;

    logic                                  clock;
    logic                                  rst_n;
    logic                                  instr_valid;
    dpm_data_pkg::instr_t                  instr;
    dpm_data_pkg::io_bus_t                 io_read_data_a;
    dpm_data_pkg::io_bus_t                 io_read_data_b;
    logic [dpm_map_pkg::IO_PORT_COUNT-1:0] io_wren_a;
    logic [dpm_map_pkg::IO_PORT_COUNT-1:0] io_wren_b;
    dpm_data_pkg::io_bus_t                 io_write_data_a;
    dpm_data_pkg::io_bus_t                 io_write_data_b;

    // Stimulus table with the I/O input words and expected result per entry
    string                                 test_name     [NUM_TESTS];
    dpm_data_pkg::instr_t                  test_instr    [NUM_TESTS];
    dpm_data_pkg::io_bus_t                 test_io_a     [NUM_TESTS];
    dpm_data_pkg::io_bus_t                 test_io_b     [NUM_TESTS];
    dpm_data_pkg::word_t                   test_expected [NUM_TESTS];
    logic [9:0]                            test_dest     [NUM_TESTS];
    int                                    table_fill;

    dpm_data_pkg::word_t                   ram_model [256];
    logic [31:0]                           lcg_state;
    logic                                  test_ok;
    int                                    test_count;
    int                                    fail_count;

    clock_gen clock_gen_inst (.clock(clock));

    dpm_top dpm_top_inst (
        .clock           (clock),
        .rst_n           (rst_n),
        .instr_valid     (instr_valid),
        .instr           (instr),
        .io_read_data_a  (io_read_data_a),
        .io_read_data_b  (io_read_data_b),
        .io_wren_a       (io_wren_a),
        .io_wren_b       (io_wren_b),
        .io_write_data_a (io_write_data_a),
        .io_write_data_b (io_write_data_b)
    );

    // ------------------------------------------------------------------
    // Reference model

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic logic is_ram_addr(input logic [9:0] addr);
        return addr >= dpm_map_pkg::MEM_BASE_ADDR && addr <= dpm_map_pkg::MEM_BOUND_ADDR;
    endfunction

    function automatic logic is_io_addr(input logic [9:0] addr);
        return addr >= IO0 && addr < IO0 + dpm_map_pkg::IO_PORT_COUNT;
    endfunction

    // Thread offset wraps inside the RAM window
    function automatic logic [9:0] translate_addr(input logic [9:0] addr, input logic thread);
        logic [7:0] idx;
        idx = addr[7:0];
        if (is_ram_addr(addr)) begin
            idx = idx + dpm_map_pkg::THREAD_OFFSET[thread];
        end
        return {addr[9:8], idx};
    endfunction

    function automatic dpm_data_pkg::word_t model_read(input logic [9:0] addr,
                                                       input logic thread,
                                                       input dpm_data_pkg::io_bus_t io);
        logic [9:0] t;
        t = translate_addr(addr, thread);
        if (is_ram_addr(t)) begin
            return ram_model[t[7:0]];
        end
        if (is_io_addr(t)) begin
            return io[t[1:0]];
        end
        return '0;
    endfunction

    // Arithmetic modulo 2^16 through the return width
    function automatic dpm_data_pkg::word_t alu_model(input dpm_data_pkg::alu_op_t op,
                                                      input dpm_data_pkg::word_t a,
                                                      input dpm_data_pkg::word_t b);
        case (op)
            dpm_data_pkg::op_add: return a + b;
            dpm_data_pkg::op_sub: return a - b;
            dpm_data_pkg::op_and: return a & b;
            dpm_data_pkg::op_or:  return a | b;
            dpm_data_pkg::op_xor: return a ^ b;
            default:              return a;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Table and checks

    task automatic add_test(input string name, input dpm_data_pkg::alu_op_t op,
                            input logic thread, input int src_a, input int src_b,
                            input int dest);
        test_name[table_fill]         = name;
        test_instr[table_fill].op     = op;
        test_instr[table_fill].thread = thread;
        test_instr[table_fill].src_a  = 10'(src_a);
        test_instr[table_fill].src_b  = 10'(src_b);
        test_instr[table_fill].dest   = 10'(dest);
        table_fill++;
    endtask

    task automatic build_table();
        add_test("io_pass_p2_to_p1", dpm_data_pkg::op_pass_a, 1'b0, IO0 + 2, 0, IO0 + 1);
        add_test("store_d_thread0", dpm_data_pkg::op_pass_a, 1'b0, IO0 + 0, 0, 310);
        add_test("store_d_thread1", dpm_data_pkg::op_pass_a, 1'b1, IO0 + 1, 0, 310);
        add_test("load_d_thread1", dpm_data_pkg::op_pass_a, 1'b1, 310, 0, IO0 + 3);
        add_test("load_d_thread0", dpm_data_pkg::op_pass_a, 1'b0, 310, 0, IO0 + 0);
        add_test("store_wrap_thread1", dpm_data_pkg::op_pass_a, 1'b1, IO0 + 2, 0, 500);
        add_test("load_wrap_thread0", dpm_data_pkg::op_pass_a, 1'b0, 308, 0, IO0 + 2);
        add_test("zero_or_unmapped", dpm_data_pkg::op_or, 1'b0, 0, 600, IO0 + 2);
        add_test("store_zero_loc", dpm_data_pkg::op_pass_a, 1'b0, IO0 + 3, 0, 0);
        add_test("load_zero_loc", dpm_data_pkg::op_or, 1'b1, 0, 100, IO0 + 1);
        add_test("store_x", dpm_data_pkg::op_pass_a, 1'b0, IO0 + 0, 0, 300);
        add_test("store_y", dpm_data_pkg::op_pass_a, 1'b0, IO0 + 3, 0, 301);
        add_test("alu_add", dpm_data_pkg::op_add, 1'b0, 300, 301, IO0 + 0);
        add_test("alu_sub", dpm_data_pkg::op_sub, 1'b0, 300, 301, IO0 + 1);
        add_test("alu_and", dpm_data_pkg::op_and, 1'b0, 300, 301, IO0 + 2);
        add_test("alu_or", dpm_data_pkg::op_or, 1'b0, 300, 301, IO0 + 3);
        add_test("alu_xor", dpm_data_pkg::op_xor, 1'b0, 300, 301, IO0 + 0);
        add_test("alu_pass_a", dpm_data_pkg::op_pass_a, 1'b0, 300, 301, IO0 + 1);
        // Independent, issued on consecutive cycles
        add_test("burst_pass", dpm_data_pkg::op_pass_a, 1'b0, IO0 + 1, 0, IO0 + 3);
        add_test("burst_xor", dpm_data_pkg::op_xor, 1'b0, IO0 + 2, IO0 + 3, IO0 + 0);
        add_test("burst_add", dpm_data_pkg::op_add, 1'b0, 300, 301, IO0 + 1);
    endtask

    // Walk the table in issue order through the model
    // The burst entries share one set of I/O input words
    task automatic fill_expected();
        logic [9:0] dest_t;
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (i <= NUM_SINGLE) begin
                for (int p = 0; p < dpm_map_pkg::IO_PORT_COUNT; p++) begin
                    test_io_a[i][p] = lcg_next();
                    test_io_b[i][p] = lcg_next();
                end
            end else begin
                test_io_a[i] = test_io_a[i-1];
                test_io_b[i] = test_io_b[i-1];
            end
            test_expected[i] = alu_model(test_instr[i].op,
                model_read(test_instr[i].src_a, test_instr[i].thread, test_io_a[i]),
                model_read(test_instr[i].src_b, test_instr[i].thread, test_io_b[i]));
            dest_t       = translate_addr(test_instr[i].dest, test_instr[i].thread);
            test_dest[i] = dest_t;
            if (is_ram_addr(dest_t)) begin
                ram_model[dest_t[7:0]] = test_expected[i];
            end
        end
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [15:0] expected, input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s %s expected %h actual %h", name, what, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    // Both banks carry the same write-back word on every port
    task automatic check_io_write(input int i);
        logic [3:0] onehot;
        onehot = 4'b0001 << test_dest[i][1:0];
        check_value(test_name[i], "io_wren_a", onehot, io_wren_a);
        check_value(test_name[i], "io_wren_b", onehot, io_wren_b);
        for (int p = 0; p < dpm_map_pkg::IO_PORT_COUNT; p++) begin
            check_value(test_name[i], "io_write_data_a", test_expected[i], io_write_data_a[p]);
            check_value(test_name[i], "io_write_data_b", test_expected[i], io_write_data_b[p]);
        end
    endtask

    task automatic wait_io_write(output int cycles, output logic found);
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
            found = (io_wren_a | io_wren_b) != '0;
        end
    endtask

    task automatic report_test(input int i);
        test_count++;
        if (test_ok) begin
            $display("PASS %s", test_name[i]);
        end else begin
            fail_count++;
            $display("Test %s failed", test_name[i]);
        end
    endtask

    // ------------------------------------------------------------------
    // Test runners

    task automatic run_single(input int i);
        int   cycles;
        logic found;
        @(posedge clock);
        io_read_data_a <= test_io_a[i];
        io_read_data_b <= test_io_b[i];
        instr_valid    <= 1'b1;
        instr          <= test_instr[i];
        @(posedge clock);
        instr_valid <= 1'b0;
        test_ok = 1'b1;
        if (is_io_addr(test_dest[i])) begin
            wait_io_write(cycles, found);
            assert (found) else begin
                $display("Test %s: no I/O write arrived within %0d cycles",
                         test_name[i], WAIT_LIMIT);
                test_ok = 1'b0;
            end
            if (found) begin
                check_value(test_name[i], "latency", LATENCY, cycles);
                check_io_write(i);
            end
        end else begin
            // RAM store or dropped write keeps both strobes low
            for (int c = 0; c < LATENCY + 2; c++) begin
                @(negedge clock);
                assert ((io_wren_a | io_wren_b) == '0) else begin
                    $display("Test %s: I/O write strobe seen on a non-I/O store",
                             test_name[i]);
                    test_ok = 1'b0;
                end
            end
        end
        report_test(i);
    endtask

    task automatic run_burst();
        int   cycles;
        logic found;
        @(posedge clock);
        io_read_data_a <= test_io_a[NUM_SINGLE];
        io_read_data_b <= test_io_b[NUM_SINGLE];
        for (int k = 0; k < NUM_BURST; k++) begin
            if (k > 0) begin
                @(posedge clock);
            end
            instr_valid <= 1'b1;
            instr       <= test_instr[NUM_SINGLE + k];
        end
        @(posedge clock);
        instr_valid <= 1'b0;
        wait_io_write(cycles, found);
        // Pulses follow on consecutive cycles, in issue order
        for (int k = 0; k < NUM_BURST; k++) begin
            test_ok = 1'b1;
            if (k > 0) begin
                @(negedge clock);
            end
            assert (found) else begin
                $display("Test %s: no I/O write arrived within %0d cycles",
                         test_name[NUM_SINGLE + k], WAIT_LIMIT);
                test_ok = 1'b0;
            end
            if (found && k == 0) begin
                check_value(test_name[NUM_SINGLE], "latency", LATENCY + 1 - NUM_BURST, cycles);
            end
            if (found) begin
                check_io_write(NUM_SINGLE + k);
            end
            report_test(NUM_SINGLE + k);
        end
    endtask

    // ------------------------------------------------------------------

    initial begin
        lcg_state      = 32'd56;
        rst_n          = 1'b0;
        instr_valid    = 1'b0;
        instr          = '0;
        io_read_data_a = '0;
        io_read_data_b = '0;
        table_fill     = 0;
        test_count     = 0;
        fail_count     = 0;
        build_table();
        fill_expected();
        repeat (5) @(posedge clock);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_SINGLE; i++) begin
            run_single(i);
        end
        run_burst();
        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 test_count, test_count - fail_count, fail_count);
        if (fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== src.f ====
logic/dpm_map_pkg.sv
logic/dpm_data_pkg.sv
logic/mem_range_decoder.sv
logic/data_memory.sv
logic/addr_translator.sv
logic/datapath_memory.sv
logic/result_alu.sv
logic/dpm_top.sv
dv/clock_gen.sv
dv/dpm_tb.sv
